// File: hdl/vec_defines.svh
/* Vector coprocessor sizes: lanes, element width, register count and queue depth */

`ifndef VEC_DEFINES_SVH
`define VEC_DEFINES_SVH

// Parallel lanes, any power of two up to 16
`define VEC_NR_LANES 4

// Element width in bits
`define VEC_ELEN 32

// Architectural vector registers
`define VEC_NR_VREGS 8

// Elements of one register held by each lane
// (16 elements spread over the lanes)
`define VEC_ROWS (16 / `VEC_NR_LANES)

// Host request and response queues
`define VEC_FIFO_DEPTH 4

`endif

// File: hdl/vec_pkg.sv
/* Shared types of the vector coprocessor: elements, register numbers, opcodes and the
   host request and response formats */

`default_nettype none

`include "vec_defines.svh"

package vec_pkg;

  // One vector element
  typedef logic [`VEC_ELEN-1:0] elen_t;

  // Vector register number
  typedef logic [$clog2(`VEC_NR_VREGS)-1:0] vreg_idx_t;

  // Supported operations
  typedef enum logic [2:0] {
    OP_VID     = 3'd0,
    OP_VMV_VX  = 3'd1,
    OP_VADD    = 3'd2,
    OP_VXOR    = 3'd3,
    OP_VREDSUM = 3'd4
  } vec_op_e;

  // Instruction as sent by the host and broadcast to the lanes
  // vs1 only matters for vadd and vxor, vs2 not for vid and vmv.v.x
  typedef struct packed {
    vec_op_e   op;
    vreg_idx_t vd;
    vreg_idx_t vs1;
    vreg_idx_t vs2;
    elen_t     scalar;
  } acc_req_t;

  // Scalar answer, zero unless the instruction was a reduction
  typedef struct packed {
    elen_t result;
  } acc_resp_t;

endpackage : vec_pkg

`default_nettype wire

// File: hdl/vec_fifo.sv
/* Small synchronous FIFO on a circular buffer, payload type set by parameter */

`timescale 1ns/10ps
`default_nettype none

module vec_fifo #(
  parameter type         T     = logic,
  parameter int unsigned DEPTH = 4
) (
  input  logic clk_i,
  input  logic rst_n_i,
  // Write side
  input  logic push_i,
  input  T     data_i,
  output logic full_o,
  // Read side
  input  logic pop_i,
  output T     data_o,
  output logic empty_o
);

  localparam int unsigned PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int unsigned CNT_W = $clog2(DEPTH + 1);

  T                 mem_q [DEPTH];
  logic [PTR_W-1:0] wr_ptr_q;
  logic [PTR_W-1:0] rd_ptr_q;
  logic [CNT_W-1:0] cnt_q;
  logic             push;
  logic             pop;

  // Push when full and pop when empty are dropped
  assign full_o  = (cnt_q == CNT_W'(DEPTH));
  assign empty_o = (cnt_q == '0);
  assign push    = push_i & ~full_o;
  assign pop     = pop_i & ~empty_o;
  assign data_o  = mem_q[rd_ptr_q];

  always_ff @(posedge clk_i) begin
    if (push) begin
      mem_q[wr_ptr_q] <= data_i;
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      cnt_q    <= '0;
    end else begin
      if (push) begin
        wr_ptr_q <= (wr_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (pop) begin
        rd_ptr_q <= (rd_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      case ({push, pop})
        2'b10:   cnt_q <= cnt_q + 1'b1;
        2'b01:   cnt_q <= cnt_q - 1'b1;
        default: cnt_q <= cnt_q;
      endcase
    end
  end

endmodule : vec_fifo

`default_nettype wire

// File: hdl/vec_dispatcher.sv
/* Dispatcher: queues host requests for the sequencer and finished responses for the host */

`timescale 1ns/10ps
`default_nettype none

`include "vec_defines.svh"

module vec_dispatcher import vec_pkg::*; (
  input  logic      clk_i,
  input  logic      rst_n_i,
  // Host request port
  input  acc_req_t  acc_req_i,
  input  logic      acc_req_valid_i,
  output logic      acc_req_ready_o,
  // Host response port
  output acc_resp_t acc_resp_o,
  output logic      acc_resp_valid_o,
  input  logic      acc_resp_ready_i,
  // Sequencer side
  output acc_req_t  insn_o,
  output logic      insn_valid_o,
  input  logic      insn_ready_i,
  input  acc_resp_t resp_i,
  input  logic      resp_valid_i,
  output logic      resp_room_o
);

  logic req_full;
  logic req_empty;
  logic req_pop;
  logic resp_full;
  logic resp_empty;
  logic resp_pop;

  ////////////////////
  // Request queue
  ////////////////////

  // Ready depends on queue space only
  assign acc_req_ready_o = ~req_full;
  assign insn_valid_o    = ~req_empty;
  assign req_pop         = insn_valid_o & insn_ready_i;

  vec_fifo #(
    .T    (acc_req_t      ),
    .DEPTH(`VEC_FIFO_DEPTH)
  ) u_req_fifo (
    .clk_i  (clk_i          ),
    .rst_n_i(rst_n_i        ),
    .push_i (acc_req_valid_i),
    .data_i (acc_req_i      ),
    .full_o (req_full       ),
    .pop_i  (req_pop        ),
    .data_o (insn_o         ),
    .empty_o(req_empty      )
  );

  ////////////////////
  // Response queue
  ////////////////////

  // Head entry stays put until the host takes it
  assign acc_resp_valid_o = ~resp_empty;
  assign resp_pop         = acc_resp_valid_o & acc_resp_ready_i;
  assign resp_room_o      = ~resp_full;

  vec_fifo #(
    .T    (acc_resp_t     ),
    .DEPTH(`VEC_FIFO_DEPTH)
  ) u_resp_fifo (
    .clk_i  (clk_i       ),
    .rst_n_i(rst_n_i     ),
    .push_i (resp_valid_i),
    .data_i (resp_i      ),
    .full_o (resp_full   ),
    .pop_i  (resp_pop    ),
    .data_o (acc_resp_o  ),
    .empty_o(resp_empty  )
  );

endmodule : vec_dispatcher

`default_nettype wire

// File: hdl/vec_sequencer.sv
/* Sequencer: runs one instruction at a time, broadcasts it to the lanes and
   builds the scalar response */

`timescale 1ns/10ps
`default_nettype none

`include "vec_defines.svh"

module vec_sequencer import vec_pkg::*; (
  input  logic                     clk_i,
  input  logic                     rst_n_i,
  // Dispatcher side
  input  acc_req_t                 insn_i,
  input  logic                     insn_valid_i,
  output logic                     insn_ready_o,
  output acc_resp_t                resp_o,
  output logic                     resp_valid_o,
  input  logic                     resp_room_i,
  // Lanes and reduction tree
  output acc_req_t                 pe_req_o,
  output logic                     pe_req_valid_o,
  input  logic [`VEC_NR_LANES-1:0] pe_done_i,
  input  elen_t                    red_sum_i,
  input  logic                     red_valid_i
);

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_ISSUE,
    ST_WAIT_LANES,
    ST_WAIT_RED
  } state_e;

  state_e                   state_q;
  acc_req_t                 insn_q;
  logic [`VEC_NR_LANES-1:0] done_seen_q;
  logic                     resp_valid_q;
  acc_resp_t                resp_q;
  logic                     insn_accept;
  logic                     lanes_done;
  logic                     fin_lanes;
  logic                     fin_red;

  // No new instruction while a response is being pushed, so resp_room_i
  // already counts it when we decide
  assign insn_ready_o = (state_q == ST_IDLE) & ~resp_valid_q & resp_room_i;
  assign insn_accept  = insn_valid_i & insn_ready_o;

  assign lanes_done = &(done_seen_q | pe_done_i);
  assign fin_lanes  = (state_q == ST_WAIT_LANES) & lanes_done & (insn_q.op != OP_VREDSUM);
  assign fin_red    = (state_q == ST_WAIT_RED) & red_valid_i;

  assign pe_req_o       = insn_q;
  assign pe_req_valid_o = (state_q == ST_ISSUE);
  assign resp_o         = resp_q;
  assign resp_valid_o   = resp_valid_q;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q      <= ST_IDLE;
      done_seen_q  <= '0;
      resp_valid_q <= 1'b0;
    end else begin
      resp_valid_q <= fin_lanes | fin_red;
      case (state_q)
        ST_IDLE: begin
          if (insn_accept) begin
            state_q <= ST_ISSUE;
          end
        end
        ST_ISSUE: begin
          done_seen_q <= '0;
          state_q     <= ST_WAIT_LANES;
        end
        ST_WAIT_LANES: begin
          done_seen_q <= done_seen_q | pe_done_i;
          if (lanes_done) begin
            // Reductions still need the adder tree
            state_q <= (insn_q.op == OP_VREDSUM) ? ST_WAIT_RED : ST_IDLE;
          end
        end
        ST_WAIT_RED: begin
          if (red_valid_i) begin
            state_q <= ST_IDLE;
          end
        end
        default: state_q <= ST_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (insn_accept) begin
      insn_q <= insn_i;
    end
    if (fin_lanes) begin
      resp_q.result <= '0;
    end else if (fin_red) begin
      resp_q.result <= red_sum_i;
    end
  end

endmodule : vec_sequencer

`default_nettype wire

// File: hdl/vec_lane.sv
/* Vector lane: register-file slice, row loop, ALU and partial sum for reductions */

`timescale 1ns/10ps
`default_nettype none

`include "vec_defines.svh"

module vec_lane import vec_pkg::*; #(
  parameter int unsigned LANE_ID = 0
) (
  input  logic     clk_i,
  input  logic     rst_n_i,
  // Broadcast from the sequencer
  input  acc_req_t pe_req_i,
  input  logic     pe_req_valid_i,
  output logic     pe_done_o,
  // To the reduction tree
  output elen_t    partial_sum_o,
  output logic     partial_valid_o
);

  localparam int unsigned ROW_W = (`VEC_ROWS > 1) ? $clog2(`VEC_ROWS) : 1;

  elen_t            vrf_q [`VEC_NR_VREGS][`VEC_ROWS];
  acc_req_t         req_q;
  logic             busy_q;
  logic [ROW_W-1:0] row_q;
  elen_t            acc_q;
  elen_t            op_a;
  elen_t            op_b;
  elen_t            result;
  logic             last_row;
  logic             wr_en;

  ////////////////////
  // Datapath
  ////////////////////

  assign op_a     = vrf_q[req_q.vs1][row_q];
  assign op_b     = vrf_q[req_q.vs2][row_q];
  assign last_row = (row_q == ROW_W'(`VEC_ROWS - 1));
  assign wr_en    = busy_q & (req_q.op != OP_VREDSUM);

  always_comb begin
    case (req_q.op)
      // Element number is row * lanes + lane
      OP_VID:    result = elen_t'(row_q) * elen_t'(`VEC_NR_LANES) + elen_t'(LANE_ID);
      OP_VMV_VX: result = req_q.scalar;
      OP_VADD:   result = op_a + op_b;
      OP_VXOR:   result = op_a ^ op_b;
      default:   result = '0;
    endcase
  end

  // Last row is folded in on the fly, so the sum is ready with done
  assign pe_done_o       = busy_q & last_row;
  assign partial_valid_o = pe_done_o & (req_q.op == OP_VREDSUM);
  assign partial_sum_o   = acc_q + op_b;

  ////////////////////
  // Row loop
  ////////////////////

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      busy_q <= 1'b0;
      row_q  <= '0;
    end else if (pe_req_valid_i) begin
      busy_q <= 1'b1;
      row_q  <= '0;
    end else if (busy_q) begin
      busy_q <= ~last_row;
      row_q  <= last_row ? '0 : row_q + 1'b1;
    end
  end

  always_ff @(posedge clk_i) begin
    if (pe_req_valid_i) begin
      req_q <= pe_req_i;
      acc_q <= '0;
    end else if (busy_q) begin
      acc_q <= acc_q + op_b;
    end
  end

  // Register slice, cleared to zero on reset
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      for (int r = 0; r < `VEC_NR_VREGS; r++) begin
        for (int w = 0; w < `VEC_ROWS; w++) begin
          vrf_q[r][w] <= '0;
        end
      end
    end else if (wr_en) begin
      vrf_q[req_q.vd][row_q] <= result;
    end
  end

endmodule : vec_lane

`default_nettype wire

// File: hdl/vec_reduce.sv
/* Two-stage pipelined adder tree that folds the lanes' partial sums and the scalar */

`timescale 1ns/10ps
`default_nettype none

`include "vec_defines.svh"

module vec_reduce import vec_pkg::*; (
  input  logic                      clk_i,
  input  logic                      rst_n_i,
  // From the lanes
  input  elen_t [`VEC_NR_LANES-1:0] partial_sum_i,
  input  logic                      partial_valid_i,
  input  elen_t                     scalar_i,
  // To the sequencer
  output elen_t                     red_sum_o,
  output logic                      red_valid_o
);

  localparam int unsigned NR_PAIRS = `VEC_NR_LANES / 2;

  elen_t [NR_PAIRS-1:0] pair_q;
  elen_t                scalar_q;
  logic                 stage1_valid_q;
  logic                 stage2_valid_q;
  elen_t                total;

  // Second stage sum of the pairs and the scalar
  always_comb begin
    total = scalar_q;
    for (int p = 0; p < NR_PAIRS; p++) begin
      total = total + pair_q[p];
    end
  end

  assign red_valid_o = stage2_valid_q;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      stage1_valid_q <= 1'b0;
      stage2_valid_q <= 1'b0;
    end else begin
      stage1_valid_q <= partial_valid_i;
      stage2_valid_q <= stage1_valid_q;
    end
  end

  always_ff @(posedge clk_i) begin
    // Stage 1, neighbouring lanes added in pairs
    if (partial_valid_i) begin
      for (int p = 0; p < NR_PAIRS; p++) begin
        pair_q[p] <= partial_sum_i[2*p] + partial_sum_i[2*p+1];
      end
      scalar_q <= scalar_i;
    end
    // Stage 2
    if (stage1_valid_q) begin
      red_sum_o <= total;
    end
  end

endmodule : vec_reduce

`default_nettype wire

// File: hdl/vec_top.sv
/* Vector coprocessor top: dispatcher, sequencer, lanes and reduction tree */

`timescale 1ns/10ps
`default_nettype none

`include "vec_defines.svh"

module vec_top import vec_pkg::*; (
  input  logic      clk_i,
  input  logic      rst_n_i,
  // Host request port
  input  acc_req_t  acc_req_i,
  input  logic      acc_req_valid_i,
  output logic      acc_req_ready_o,
  // Host response port
  output acc_resp_t acc_resp_o,
  output logic      acc_resp_valid_o,
  input  logic      acc_resp_ready_i
);

  // Dispatcher and sequencer
  acc_req_t                  insn;
  logic                      insn_valid;
  logic                      insn_ready;
  acc_resp_t                 resp;
  logic                      resp_valid;
  logic                      resp_room;
  // Sequencer and lanes
  acc_req_t                  pe_req;
  logic                      pe_req_valid;
  logic [`VEC_NR_LANES-1:0]  pe_done;
  // Lanes and reduction tree
  elen_t [`VEC_NR_LANES-1:0] partial_sum;
  logic [`VEC_NR_LANES-1:0]  lane_partial_valid;
  logic                      partial_valid;
  elen_t                     red_sum;
  logic                      red_valid;

  ////////////////////
  // Front end
  ////////////////////

  vec_dispatcher u_dispatcher (
    .clk_i           (clk_i           ),
    .rst_n_i         (rst_n_i         ),
    .acc_req_i       (acc_req_i       ),
    .acc_req_valid_i (acc_req_valid_i ),
    .acc_req_ready_o (acc_req_ready_o ),
    .acc_resp_o      (acc_resp_o      ),
    .acc_resp_valid_o(acc_resp_valid_o),
    .acc_resp_ready_i(acc_resp_ready_i),
    .insn_o          (insn            ),
    .insn_valid_o    (insn_valid      ),
    .insn_ready_i    (insn_ready      ),
    .resp_i          (resp            ),
    .resp_valid_i    (resp_valid      ),
    .resp_room_o     (resp_room       )
  );

  vec_sequencer u_sequencer (
    .clk_i         (clk_i       ),
    .rst_n_i       (rst_n_i     ),
    .insn_i        (insn        ),
    .insn_valid_i  (insn_valid  ),
    .insn_ready_o  (insn_ready  ),
    .resp_o        (resp        ),
    .resp_valid_o  (resp_valid  ),
    .resp_room_i   (resp_room   ),
    .pe_req_o      (pe_req      ),
    .pe_req_valid_o(pe_req_valid),
    .pe_done_i     (pe_done     ),
    .red_sum_i     (red_sum     ),
    .red_valid_i   (red_valid   )
  );

  ////////////////////
  // Lanes
  ////////////////////

  for (genvar l = 0; l < `VEC_NR_LANES; l++) begin : gen_lanes
    vec_lane #(
      .LANE_ID(l)
    ) u_lane (
      .clk_i          (clk_i                ),
      .rst_n_i        (rst_n_i              ),
      .pe_req_i       (pe_req               ),
      .pe_req_valid_i (pe_req_valid         ),
      .pe_done_o      (pe_done[l]           ),
      .partial_sum_o  (partial_sum[l]       ),
      .partial_valid_o(lane_partial_valid[l])
    );
  end : gen_lanes

  // Lanes run in lockstep, lane 0 speaks for all
  assign partial_valid = lane_partial_valid[0];

  vec_reduce u_reduce (
    .clk_i          (clk_i        ),
    .rst_n_i        (rst_n_i      ),
    .partial_sum_i  (partial_sum  ),
    .partial_valid_i(partial_valid),
    .scalar_i       (pe_req.scalar),
    .red_sum_o      (red_sum      ),
    .red_valid_o    (red_valid    )
  );

endmodule : vec_top

`default_nettype wire

// File: verif/vec_chk.sv
/* Protocol checker for the vector coprocessor host ports and internal strobes,
   bound into vec_top */

`timescale 1ns/10ps
`default_nettype none

module vec_chk import vec_pkg::*; (
  input logic      clk_i,
  input logic      rst_n_i,
  input acc_req_t  acc_req_i,
  input logic      acc_req_valid_i,
  input logic      acc_req_ready_i,
  input acc_resp_t acc_resp_i,
  input logic      acc_resp_valid_i,
  input logic      acc_resp_ready_i,
  input logic      pe_req_valid_i,
  input logic      resp_valid_i,
  input logic      red_valid_i,
  input logic      partial_valid_i
);

  int fail_cnt = 0;

  // Held response must not move or vanish
  a_resp_stable: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    acc_resp_valid_i && !acc_resp_ready_i |=> acc_resp_valid_i && $stable(acc_resp_i))
  else begin
    $error("response changed or dropped under back-pressure");
    fail_cnt++;
  end

  // Host side rule
  a_req_stable: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    acc_req_valid_i && !acc_req_ready_i |=> acc_req_valid_i && $stable(acc_req_i))
  else begin
    $error("request changed or withdrawn before it was accepted");
    fail_cnt++;
  end

  a_reset_quiet: assert property (@(posedge clk_i)
    !rst_n_i |-> !(acc_resp_valid_i | pe_req_valid_i | resp_valid_i | red_valid_i |
                   partial_valid_i))
  else begin
    $error("valid strobe high during reset");
    fail_cnt++;
  end

endmodule : vec_chk

bind vec_top vec_chk u_chk (
  .clk_i           (clk_i           ),
  .rst_n_i         (rst_n_i         ),
  .acc_req_i       (acc_req_i       ),
  .acc_req_valid_i (acc_req_valid_i ),
  .acc_req_ready_i (acc_req_ready_o ),
  .acc_resp_i      (acc_resp_o      ),
  .acc_resp_valid_i(acc_resp_valid_o),
  .acc_resp_ready_i(acc_resp_ready_i),
  .pe_req_valid_i  (pe_req_valid    ),
  .resp_valid_i    (resp_valid      ),
  .red_valid_i     (red_valid       ),
  .partial_valid_i (partial_valid   )
);

`default_nettype wire

// File: verif/vec_tb.sv
/* Testbench for the vector coprocessor: register-file model, in-order response
   checks and back-pressure */

`timescale 1ns/10ps
`default_nettype none

`include "vec_defines.svh"

module vec_tb import vec_pkg::*; ;

  localparam int NR_ELEM        = `VEC_NR_LANES * `VEC_ROWS;
  localparam int TIMEOUT_CYCLES = 400;
  localparam int STALL_CYCLES   = 20;

  logic      clk = 1'b0;
  logic      rst_n;
  acc_req_t  acc_req_i;
  logic      acc_req_valid_i;
  logic      acc_req_ready_o;
  acc_resp_t acc_resp_o;
  logic      acc_resp_valid_o;
  logic      acc_resp_ready_i;

  integer      seed = 32'h039c_aa6b;
  logic [31:0] model [`VEC_NR_VREGS][NR_ELEM];
  logic [31:0] exp_q [$];
  int          err_cnt     = 0;
  int          timeout_cnt = 0;
  int          req_cnt     = 0;
  int          resp_cnt    = 0;

  always #10 clk = ~clk;

  vec_top u_dut (
    .clk_i           (clk             ),
    .rst_n_i         (rst_n           ),
    .acc_req_i       (acc_req_i       ),
    .acc_req_valid_i (acc_req_valid_i ),
    .acc_req_ready_o (acc_req_ready_o ),
    .acc_resp_o      (acc_resp_o      ),
    .acc_resp_valid_o(acc_resp_valid_o),
    .acc_resp_ready_i(acc_resp_ready_i)
  );

  ////////////////////
  // Run control
  ////////////////////

  task automatic end_run();
    int chk_fails;
    chk_fails = u_dut.u_chk.fail_cnt;
    $display("Errors: %0d value, %0d assertion, %0d timeout",
             err_cnt, chk_fails, timeout_cnt);
    if (err_cnt == 0 && chk_fails == 0 && timeout_cnt == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  endtask

  task automatic report_timeout(input string what);
    timeout_cnt++;
    $display("Timeout at %0t: %s", $time, what);
  endtask

  ////////////////////
  // Stimulus
  ////////////////////

  // Called and returns 2 ns after a rising edge
  task automatic send_req(input acc_req_t req, input logic [31:0] exp_val);
    int   waited;
    logic taken;
    waited          = 0;
    taken           = 1'b0;
    acc_req_i       = req;
    acc_req_valid_i = 1'b1;
    while (!taken && waited < TIMEOUT_CYCLES) begin
      taken = acc_req_ready_o;
      @(posedge clk);
      #2;
      waited++;
    end
    acc_req_valid_i = 1'b0;
    if (!taken) begin
      report_timeout("request was never accepted");
    end else begin
      exp_q.push_back(exp_val);
      req_cnt++;
    end
  endtask

  // Updates the model by the operation rules, then sends
  task automatic issue(input vec_op_e op, input int vd, input int vs1, input int vs2,
                       input logic [31:0] scalar);
    acc_req_t    req;
    logic [31:0] exp_val;
    exp_val = '0;
    for (int e = 0; e < NR_ELEM; e++) begin
      case (op)
        OP_VID:     model[vd][e] = e;
        OP_VMV_VX:  model[vd][e] = scalar;
        OP_VADD:    model[vd][e] = model[vs1][e] + model[vs2][e];
        OP_VXOR:    model[vd][e] = model[vs1][e] ^ model[vs2][e];
        default:    exp_val      = exp_val + model[vs2][e];
      endcase
    end
    if (op == OP_VREDSUM) exp_val = exp_val + scalar;
    req.op     = op;
    req.vd     = vreg_idx_t'(vd);
    req.vs1    = vreg_idx_t'(vs1);
    req.vs2    = vreg_idx_t'(vs2);
    req.scalar = scalar;
    send_req(req, exp_val);
  endtask

  task automatic wait_drain();
    int waited;
    waited = 0;
    while (exp_q.size() != 0 && waited < TIMEOUT_CYCLES) begin
      @(posedge clk);
      #2;
      waited++;
    end
    if (exp_q.size() != 0) report_timeout("responses still outstanding");
  endtask

  ////////////////////
  // Response check
  ////////////////////

  // Mid-cycle sample, transfer happens at the next rising edge
  initial begin : collect_resp
    logic [31:0] exp_val;
    forever begin
      @(negedge clk);
      if (rst_n && acc_resp_valid_o && acc_resp_ready_i) begin
        assert (exp_q.size() != 0) else begin
          err_cnt++;
          $display("Unexpected response at %0t with no request outstanding", $time);
        end
        if (exp_q.size() != 0) begin
          exp_val = exp_q.pop_front();
          assert (acc_resp_o.result == exp_val) else begin
            err_cnt++;
            $display("** Error at %0t: response %0d expected %h, got %h",
                     $time, resp_cnt, exp_val, acc_resp_o.result);
          end
        end
        resp_cnt++;
      end
    end
  end

  ////////////////////
  // Main sequence
  ////////////////////

  initial begin : main
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] s;
    int          sent;
    int          waited;
    logic        stalled;
    rst_n            = 1'b0;
    acc_req_i        = '0;
    acc_req_valid_i  = 1'b0;
    acc_resp_ready_i = 1'b1;
    for (int r = 0; r < `VEC_NR_VREGS; r++) begin
      for (int e = 0; e < NR_ELEM; e++) begin
        model[r][e] = '0;
      end
    end
    repeat (16) @(posedge clk);
    #2;
    rst_n = 1'b1;

    assert (!acc_resp_valid_o && acc_req_ready_o) else begin
      err_cnt++;
      $display("** Error at %0t: after reset expected valid 0 ready 1, got valid %b ready %b",
               $time, acc_resp_valid_o, acc_req_ready_o);
    end

    // Sum of 0..15 is 120
    s = $random(seed);
    issue(OP_VID, 1, 0, 0, '0);
    issue(OP_VREDSUM, 0, 0, 1, s);

    for (int i = 0; i < 3; i++) begin
      a = $random(seed);
      b = $random(seed);
      s = $random(seed);
      issue(OP_VMV_VX, 2, 0, 0, a);
      issue(OP_VMV_VX, 3, 0, 0, b);
      issue(OP_VADD, 4, 2, 3, '0);
      issue(OP_VXOR, 5, 2, 3, '0);
      issue(OP_VREDSUM, 0, 0, 4, s);
      issue(OP_VREDSUM, 0, 0, 5, s);
      issue(OP_VADD, 6, 1, 4, '0);
      issue(OP_VREDSUM, 0, 0, 6, s);
    end
    wait_drain();

    // Back-pressure until the request port stays stalled
    acc_resp_ready_i = 1'b0;
    sent             = 0;
    stalled          = 1'b0;
    while (!stalled && sent < 32) begin
      if (sent % 2 == 0) begin
        issue(OP_VMV_VX, 7, 0, 0, $random(seed));
      end else begin
        issue(OP_VREDSUM, 0, 0, 7, $random(seed));
      end
      sent++;
      // Only a full response queue keeps the port low for good
      waited = 0;
      while (!acc_req_ready_o && waited < STALL_CYCLES) begin
        @(posedge clk);
        #2;
        waited++;
      end
      stalled = !acc_req_ready_o;
    end
    if (!stalled) report_timeout("request port never stalled under back-pressure");
    acc_resp_ready_i = 1'b1;
    wait_drain();

    assert (resp_cnt == req_cnt) else begin
      err_cnt++;
      $display("** Error at %0t: expected %0d responses, got %0d", $time, req_cnt, resp_cnt);
    end
    end_run();
  end

endmodule : vec_tb

`default_nettype wire

// File: src.f
+incdir+hdl
hdl/vec_pkg.sv
hdl/vec_fifo.sv
hdl/vec_dispatcher.sv
hdl/vec_sequencer.sv
hdl/vec_lane.sv
hdl/vec_reduce.sv
hdl/vec_top.sv
verif/vec_chk.sv
verif/vec_tb.sv
